// ==== hw/link_pkg.sv ====
// ----------------------------------------
// SPI word layout and link protocol codes
// Ids from NUM_CHANNELS up are special or
// dropped by the controller
// ----------------------------------------
package link_pkg;

    // High byte selects the channel, low byte is the payload
    typedef struct packed {
        logic [7:0] chan_id;
        logic [7:0] code;
    } link_word_t;

    localparam link_word_t PIPE_MODE_CMD = 16'hA55A;
    localparam link_word_t NOP_WORD      = 16'hF000;

    localparam logic [7:0] SHOOT_ID = 8'hFF;
    localparam logic [7:0] ERR_ID   = 8'hEE;

    typedef enum logic [7:0] {
        ERR_TIMEOUT = 8'hE1,
        ERR_PARITY  = 8'hE2
    } err_code_e;

    typedef enum logic [1:0] {
        WAIT_MODE,
        PIPE_MODE,
        NORMAL_MODE
    } ctrl_state_e;

    typedef enum logic [1:0] {
        PIPE_IDLE,
        PIPE_SEND,
        PIPE_WAIT,
        PIPE_REPLY
    } pipe_state_e;

endpackage

// ==== hw/board_pkg.sv ====
// ----------------------------------------
// Board timing, all counts in clk cycles
// Windows assume the clock of the board
// ----------------------------------------
package board_pkg;

    localparam int NUM_CHANNELS = 9;
    localparam int CHAN_ID_W    = $clog2(NUM_CHANNELS);

    // UART bit period
    localparam int CLKS_PER_BIT = 8;
    localparam int BIT_CLK_W    = $clog2(CLKS_PER_BIT);

    // SCLK half period and full transfer length, accept to done
    localparam int SPI_HALF_PERIOD = 2;
    localparam int SPI_DIV_W       = $clog2(SPI_HALF_PERIOD + 1);
    localparam int SPI_XFER_CYCLES = 32 * SPI_HALF_PERIOD + 2;

    localparam int STARTUP_CYCLES = 2000;
    localparam int STARTUP_W      = $clog2(STARTUP_CYCLES);

    localparam int REPLY_TIMEOUT = 400;
    localparam int REPLY_W       = $clog2(REPLY_TIMEOUT);

    localparam int SHOOT_CYCLES = 16;
    localparam int SHOOT_W      = $clog2(SHOOT_CYCLES + 1);

endpackage

// ==== hw/link_ifs.sv ====
// ----------------------------------------
// Controller side buses
// spi_xfer_if carries one word per request
// chan_if carries one byte each way
// ----------------------------------------
`timescale 1ns/1ps

interface spi_xfer_if;
    logic                 valid;
    logic                 ready;
    logic                 done;
    link_pkg::link_word_t tx_word;
    link_pkg::link_word_t rx_word;

    modport master_side (
        input  valid, tx_word,
        output ready, done, rx_word
    );

    modport ctrl_side (
        output valid, tx_word,
        input  ready, done, rx_word
    );
endinterface

interface chan_if;
    logic       tx_valid;
    logic       tx_ready;
    logic [7:0] tx_data;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       rx_parity_err;

    modport uart_side (
        input  tx_valid, tx_data,
        output tx_ready, rx_valid, rx_data, rx_parity_err
    );

    modport ctrl_side (
        output tx_valid, tx_data,
        input  tx_ready, rx_valid, rx_data, rx_parity_err
    );
endinterface

// ==== hw/spi_master.sv ====
// ----------------------------------------
// SPI master, mode 0, MSB first
// One 16-bit full duplex word per request
// rx_word is only meaningful with done
// ----------------------------------------
`timescale 1ns/1ps

module spi_master (
    input  logic                clk,
    input  logic                rst,
    spi_xfer_if.master_side     xfer,
    output logic                sclk,
    output logic                mosi,
    output logic                cs_n,
    input  logic                miso
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_SHIFT,
        S_HOLD,
        S_END
    } spi_state_e;

    spi_state_e                     state;
    logic [board_pkg::SPI_DIV_W-1:0] div_cnt;
    logic [5:0]                     edge_cnt;
    logic [15:0]                    tx_sh;
    logic [15:0]                    rx_sh;
    logic                           done_r;

    assign xfer.ready   = (state == S_IDLE) && !done_r;
    assign xfer.done    = done_r;
    assign xfer.rx_word = rx_sh;
    assign mosi         = tx_sh[15];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            sclk     <= 1'b0;
            cs_n     <= 1'b1;
            done_r   <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
            tx_sh    <= '0;
        end else begin
            done_r <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (xfer.valid && xfer.ready) begin
                        tx_sh    <= xfer.tx_word;
                        cs_n     <= 1'b0;
                        div_cnt  <= '0;
                        edge_cnt <= '0;
                        state    <= S_SHIFT;
                    end
                end
                S_SHIFT: begin
                    if (div_cnt == board_pkg::SPI_DIV_W'(board_pkg::SPI_HALF_PERIOD - 1)) begin
                        div_cnt  <= '0;
                        sclk     <= !sclk;
                        edge_cnt <= edge_cnt + 6'd1;
                        // Sample on the rising edge, next bit out on the falling edge
                        if (!sclk) begin
                            rx_sh <= {rx_sh[14:0], miso};
                        end else begin
                            tx_sh <= {tx_sh[14:0], 1'b0};
                        end
                        if (edge_cnt == 6'd31) begin
                            state <= S_HOLD;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                // One clock of hold after the last falling edge
                S_HOLD: begin
                    cs_n  <= 1'b1;
                    state <= S_END;
                end
                default: begin
                    done_r <= 1'b1;
                    state  <= S_IDLE;
                end
            endcase
        end
    end

    // Chip select low for the whole word
    a_cs_low: assert property (@(posedge clk) disable iff (rst)
        (xfer.valid && xfer.ready) |=> !cs_n [*(board_pkg::SPI_XFER_CYCLES - 1)]);

endmodule

// ==== hw/uart_channel.sv ====
// ----------------------------------------
// UART for one power module link
// 8N data, even parity, one stop bit
// Stop bit level is not checked on receive
// ----------------------------------------
`timescale 1ns/1ps

module uart_channel (
    input  logic          clk,
    input  logic          rst,
    chan_if.uart_side     link,
    output logic          tx,
    input  logic          rx
);

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_e;

    typedef enum logic {
        RX_IDLE,
        RX_RUN
    } rx_state_e;

    localparam logic [board_pkg::BIT_CLK_W-1:0] BIT_LAST =
        board_pkg::BIT_CLK_W'(board_pkg::CLKS_PER_BIT - 1);
    localparam logic [board_pkg::BIT_CLK_W-1:0] BIT_MID =
        board_pkg::BIT_CLK_W'(board_pkg::CLKS_PER_BIT / 2 - 1);

    tx_state_e                       tx_state;
    logic [board_pkg::BIT_CLK_W-1:0] tx_clk;
    logic [3:0]                      tx_bit;
    logic [9:0]                      tx_sh;

    rx_state_e                       rx_state;
    logic [board_pkg::BIT_CLK_W-1:0] rx_clk;
    logic [3:0]                      rx_bit;
    logic [8:0]                      rx_sh;
    logic                            rx_meta;
    logic                            rx_s;
    logic                            rx_valid_r;

    assign link.tx_ready      = (tx_state == TX_IDLE);
    assign link.rx_valid      = rx_valid_r;
    assign link.rx_data       = rx_sh[7:0];
    // Even parity over data and parity bit
    assign link.rx_parity_err = ^rx_sh;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_state <= TX_IDLE;
            tx       <= 1'b1;
            tx_clk   <= '0;
            tx_bit   <= '0;
        end else begin
            case (tx_state)
                TX_IDLE: begin
                    if (link.tx_valid) begin
                        // Stop, parity, data; start bit goes out right away
                        tx_sh    <= {1'b1, ^link.tx_data, link.tx_data};
                        tx       <= 1'b0;
                        tx_clk   <= '0;
                        tx_bit   <= '0;
                        tx_state <= TX_SEND;
                    end
                end
                default: begin
                    if (tx_clk == BIT_LAST) begin
                        tx_clk <= '0;
                        if (tx_bit == 4'd10) begin
                            tx_state <= TX_IDLE;
                        end else begin
                            tx     <= tx_sh[0];
                            tx_sh  <= {1'b1, tx_sh[9:1]};
                            tx_bit <= tx_bit + 4'd1;
                        end
                    end else begin
                        tx_clk <= tx_clk + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta    <= 1'b1;
            rx_s       <= 1'b1;
            rx_state   <= RX_IDLE;
            rx_valid_r <= 1'b0;
            rx_clk     <= '0;
            rx_bit     <= '0;
        end else begin
            rx_meta    <= rx;
            rx_s       <= rx_meta;
            rx_valid_r <= 1'b0;
            case (rx_state)
                RX_IDLE: begin
                    if (!rx_s) begin
                        rx_clk   <= '0;
                        rx_bit   <= '0;
                        rx_state <= RX_RUN;
                    end
                end
                default: begin
                    if (rx_clk == BIT_LAST) begin
                        rx_clk <= '0;
                        rx_bit <= rx_bit + 4'd1;
                    end else begin
                        rx_clk <= rx_clk + 1'b1;
                    end
                    // Mid-bit sampling
                    if (rx_clk == BIT_MID) begin
                        if (rx_bit == 4'd0) begin
                            // Glitch, not a start bit
                            if (rx_s) begin
                                rx_state <= RX_IDLE;
                            end
                        end else if (rx_bit == 4'd10) begin
                            rx_valid_r <= 1'b1;
                            rx_state   <= RX_IDLE;
                        end else begin
                            rx_sh <= {rx_s, rx_sh[8:1]};
                        end
                    end
                end
            endcase
        end
    end

    a_tx_valid_held: assert property (@(posedge clk) disable iff (rst)
        (link.tx_valid && !link.tx_ready) |=> link.tx_valid);

endmodule

// ==== hw/link_controller.sv ====
// ----------------------------------------
// Mode FSM and word dispatch
// Mode is fixed until the next reset
// Pipe mode keeps one word in flight
// ----------------------------------------
`timescale 1ns/1ps

module link_controller (
    input  logic          clk,
    input  logic          rst,
    spi_xfer_if.ctrl_side xfer,
    chan_if.ctrl_side     chans [board_pkg::NUM_CHANNELS],
    output logic          led_pipe,
    output logic          led_normal,
    output logic          shoot
);

    localparam int NCH = board_pkg::NUM_CHANNELS;

    link_pkg::ctrl_state_e              state;
    link_pkg::pipe_state_e              pipe_st;
    logic [board_pkg::STARTUP_W-1:0]    startup_cnt;
    logic [board_pkg::REPLY_W-1:0]      reply_cnt;
    logic [board_pkg::SHOOT_W-1:0]      shoot_cnt;
    logic                               spi_busy;
    logic                               hold;
    logic                               reply_pend;
    logic                               issue_ok;
    logic                               send_req;
    link_pkg::link_word_t               cur_word;
    link_pkg::link_word_t               reply_word;
    logic [board_pkg::CHAN_ID_W-1:0]    cur_ch;
    logic [NCH-1:0]                     tx_valid_v;
    logic [NCH-1:0]                     tx_ready_v;
    logic [NCH-1:0]                     rx_valid_v;
    logic [NCH-1:0]                     rx_perr_v;
    logic [7:0]                         rx_data_v [NCH];

    assign cur_ch   = cur_word.chan_id[board_pkg::CHAN_ID_W-1:0];
    assign send_req = (state == link_pkg::PIPE_MODE && pipe_st == link_pkg::PIPE_SEND) ||
                      (state == link_pkg::NORMAL_MODE && hold);

    for (genvar i = 0; i < NCH; i++) begin : g_chan
        assign tx_valid_v[i]     = send_req && (cur_ch == board_pkg::CHAN_ID_W'(i));
        assign chans[i].tx_valid = tx_valid_v[i];
        assign chans[i].tx_data  = cur_word.code;
        assign tx_ready_v[i]     = chans[i].tx_ready;
        assign rx_valid_v[i]     = chans[i].rx_valid;
        assign rx_perr_v[i]      = chans[i].rx_parity_err;
        assign rx_data_v[i]      = chans[i].rx_data;
    end

    // Keep polling unless a word is still on its way to a module
    always_comb begin
        case (state)
            link_pkg::WAIT_MODE: issue_ok = 1'b1;
            link_pkg::PIPE_MODE: issue_ok = (pipe_st == link_pkg::PIPE_IDLE);
            default:             issue_ok = !hold;
        endcase
    end

    assign xfer.valid   = issue_ok && !spi_busy;
    assign xfer.tx_word = reply_pend ? reply_word : link_pkg::NOP_WORD;
    assign led_pipe     = (state == link_pkg::PIPE_MODE);
    assign led_normal   = (state == link_pkg::NORMAL_MODE);
    assign shoot        = (shoot_cnt != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= link_pkg::WAIT_MODE;
            pipe_st     <= link_pkg::PIPE_IDLE;
            startup_cnt <= '0;
            reply_cnt   <= '0;
            shoot_cnt   <= '0;
            spi_busy    <= 1'b0;
            hold        <= 1'b0;
            reply_pend  <= 1'b0;
        end else begin
            if (xfer.valid && xfer.ready) begin
                spi_busy   <= 1'b1;
                reply_pend <= 1'b0;
            end else if (xfer.done) begin
                spi_busy <= 1'b0;
            end
            if (shoot_cnt != '0) begin
                shoot_cnt <= shoot_cnt - 1'b1;
            end
            case (state)
                link_pkg::WAIT_MODE: begin
                    startup_cnt <= startup_cnt + 1'b1;
                    if (xfer.done && xfer.rx_word == link_pkg::PIPE_MODE_CMD) begin
                        state <= link_pkg::PIPE_MODE;
                    end else if (startup_cnt ==
                                 board_pkg::STARTUP_W'(board_pkg::STARTUP_CYCLES - 1)) begin
                        state <= link_pkg::NORMAL_MODE;
                    end
                end
                link_pkg::PIPE_MODE: begin
                    case (pipe_st)
                        link_pkg::PIPE_IDLE: begin
                            if (xfer.done && xfer.rx_word.chan_id < 8'(NCH)) begin
                                cur_word <= xfer.rx_word;
                                pipe_st  <= link_pkg::PIPE_SEND;
                            end
                        end
                        link_pkg::PIPE_SEND: begin
                            if (tx_ready_v[cur_ch]) begin
                                reply_cnt <= '0;
                                pipe_st   <= link_pkg::PIPE_WAIT;
                            end
                        end
                        link_pkg::PIPE_WAIT: begin
                            reply_cnt <= reply_cnt + 1'b1;
                            if (rx_valid_v[cur_ch]) begin
                                reply_word.chan_id <= rx_perr_v[cur_ch] ?
                                                      link_pkg::ERR_ID : cur_word.chan_id;
                                reply_word.code    <= rx_perr_v[cur_ch] ?
                                                      link_pkg::ERR_PARITY : rx_data_v[cur_ch];
                                pipe_st            <= link_pkg::PIPE_REPLY;
                            end else if (reply_cnt ==
                                         board_pkg::REPLY_W'(board_pkg::REPLY_TIMEOUT - 1)) begin
                                reply_word <= {link_pkg::ERR_ID, link_pkg::ERR_TIMEOUT};
                                pipe_st    <= link_pkg::PIPE_REPLY;
                            end
                        end
                        default: begin
                            reply_pend <= 1'b1;
                            pipe_st    <= link_pkg::PIPE_IDLE;
                        end
                    endcase
                end
                default: begin
                    if (hold && tx_ready_v[cur_ch]) begin
                        hold <= 1'b0;
                    end else if (xfer.done) begin
                        if (xfer.rx_word.chan_id == link_pkg::SHOOT_ID) begin
                            shoot_cnt <= board_pkg::SHOOT_W'(board_pkg::SHOOT_CYCLES);
                        end else if (xfer.rx_word.chan_id < 8'(NCH)) begin
                            cur_word <= xfer.rx_word;
                            hold     <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    a_shoot_normal: assert property (@(posedge clk) disable iff (rst)
        $rose(shoot) |-> state == link_pkg::NORMAL_MODE);

    a_one_tx_valid: assert property (@(posedge clk) disable iff (rst)
        $onehot0(tx_valid_v));

endmodule

// ==== hw/inverter_link_top.sv ====
// ----------------------------------------
// Inverter link controller top level
// Clock comes from a board pin
// uart_rx lines idle high
// ----------------------------------------
`timescale 1ns/1ps

module inverter_link_top (
    input  logic                              clk,
    input  logic                              rst,
    output logic                              spi_sclk,
    output logic                              spi_mosi,
    output logic                              spi_cs_n,
    input  logic                              spi_miso,
    output logic [board_pkg::NUM_CHANNELS-1:0] uart_tx,
    input  logic [board_pkg::NUM_CHANNELS-1:0] uart_rx,
    output logic                              led_pipe,
    output logic                              led_normal,
    output logic                              shoot
);

    spi_xfer_if xfer_bus ();
    chan_if     chan_bus [board_pkg::NUM_CHANNELS] ();

    spi_master spi_master_i (
        .clk  (clk),
        .rst  (rst),
        .xfer (xfer_bus),
        .sclk (spi_sclk),
        .mosi (spi_mosi),
        .cs_n (spi_cs_n),
        .miso (spi_miso)
    );

    // One UART per power module
    for (genvar i = 0; i < board_pkg::NUM_CHANNELS; i++) begin : g_uart
        uart_channel uart_channel_i (
            .clk  (clk),
            .rst  (rst),
            .link (chan_bus[i]),
            .tx   (uart_tx[i]),
            .rx   (uart_rx[i])
        );
    end

    link_controller link_controller_i (
        .clk        (clk),
        .rst        (rst),
        .xfer       (xfer_bus),
        .chans      (chan_bus),
        .led_pipe   (led_pipe),
        .led_normal (led_normal),
        .shoot      (shoot)
    );

endmodule

// ==== test/tb_models.sv ====
// ----------------------------------------
// Microcontroller SPI slave and module
// UART models, all lines driven on negedge
// Channel 3 is mute, channel 5 bad parity
// ----------------------------------------
`timescale 1ns/1ps

module spi_slave_model (
    input  logic                 clk,
    input  logic                 sclk,
    input  logic                 mosi,
    input  logic                 cs_n,
    output logic                 miso,
    input  link_pkg::link_word_t next_word,
    input  logic                 next_avail,
    output logic                 take,
    output logic                 got_word,
    output link_pkg::link_word_t word
);

    logic                 prev_sclk = 1'b0;
    logic                 prev_cs   = 1'b1;
    link_pkg::link_word_t tx_sh     = '0;
    link_pkg::link_word_t rx_sh     = '0;
    int                   nbits     = 0;

    initial begin
        miso     = 1'b0;
        take     = 1'b0;
        got_word = 1'b0;
        word     = '0;
    end

    always @(negedge clk) begin
        take     = 1'b0;
        got_word = 1'b0;
        if (prev_cs && !cs_n) begin
            // Queue head, or a NOP when nothing is waiting
            tx_sh = next_avail ? next_word : link_pkg::NOP_WORD;
            miso  = tx_sh[15];
            take  = next_avail;
            nbits = 0;
        end else if (!cs_n && !prev_sclk && sclk) begin
            rx_sh = {rx_sh[14:0], mosi};
            nbits = nbits + 1;
        end else if (!cs_n && prev_sclk && !sclk) begin
            tx_sh = {tx_sh[14:0], 1'b0};
            miso  = tx_sh[15];
        end
        // Words cut short by a reset are not logged
        if (!prev_cs && cs_n && nbits == 16) begin
            word     = rx_sh;
            got_word = 1'b1;
        end
        prev_sclk = sclk;
        prev_cs   = cs_n;
    end

endmodule

module uart_module_model #(
    parameter int CH = 0
) (
    input  logic       clk,
    input  logic       line_in,
    output logic       line_out,
    output logic       got,
    output logic [7:0] data
);

    localparam int BIT = board_pkg::CLKS_PER_BIT;

    int         seed = 32'h1c56_6d5b;
    logic [7:0] b;
    logic [7:0] reply;
    logic       par;

    task automatic send_bit(input logic v);
        line_out = v;
        repeat (BIT) @(negedge clk);
    endtask

    initial begin
        line_out = 1'b1;
        got      = 1'b0;
        data     = '0;
        forever begin
            @(negedge clk);
            if (!line_in) begin
                // Move to the middle of the start bit, then one bit at a time
                repeat (BIT / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT) @(negedge clk);
                    b[i] = line_in;
                end
                repeat (2 * BIT) @(negedge clk);
                data = b;
                got  = 1'b1;
                @(negedge clk);
                got = 1'b0;
                if (CH != 3) begin
                    repeat (4 + ($random(seed) & 31)) @(negedge clk);
                    reply = b ^ 8'h5A;
                    par   = (CH == 5) ? !(^reply) : ^reply;
                    send_bit(1'b0);
                    for (int i = 0; i < 8; i++) begin
                        send_bit(reply[i]);
                    end
                    send_bit(par);
                    send_bit(1'b1);
                end
            end
        end
    end

endmodule

// ==== test/tb_inverter_link.sv ====
// ----------------------------------------
// Testbench for the inverter link top
// Normal mode first, then pipe mode
// after a second reset
// ----------------------------------------
`timescale 1ns/1ps

module tb_inverter_link;

    localparam int NCH     = board_pkg::NUM_CHANNELS;
    localparam int N_WORDS = 14;
    localparam int SETTLE  = 600;
    localparam int LIMIT   = 2 * (2 * board_pkg::STARTUP_CYCLES + SETTLE +
        N_WORDS * (3 * board_pkg::SPI_XFER_CYCLES + 22 * board_pkg::CLKS_PER_BIT +
        board_pkg::REPLY_TIMEOUT));

    logic clk, rst, spi_sclk, spi_mosi, spi_cs_n, spi_miso;
    logic led_pipe, led_normal, shoot;
    logic [NCH-1:0] uart_tx, uart_rx, byte_valid;
    logic [7:0] byte_data [NCH];
    logic take, got_word, next_avail;
    link_pkg::link_word_t word, next_word;

    link_pkg::link_word_t send_q [$];
    link_pkg::link_word_t exp_reply [$];
    int exp_ch [$];
    logic [7:0] exp_code [$];
    int cycles = 0;
    int shoot_len = 0;
    int shoot_pulses = 0;
    int startup_wait = 0;

    inverter_link_top dut_i (.*);

    spi_slave_model spi_model_i (
        .clk (clk), .sclk (spi_sclk), .mosi (spi_mosi), .cs_n (spi_cs_n), .miso (spi_miso),
        .next_word (next_word), .next_avail (next_avail), .take (take),
        .got_word (got_word), .word (word)
    );

    for (genvar i = 0; i < NCH; i++) begin : g_mod
        uart_module_model #(.CH(i)) module_i (
            .clk (clk), .line_in (uart_tx[i]), .line_out (uart_rx[i]),
            .got (byte_valid[i]), .data (byte_data[i])
        );
    end

    initial begin
        clk = 1'b0;
        forever #4 clk = !clk;
    end

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic fail_plain(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic check_word(input string name, input link_pkg::link_word_t exp,
                              input link_pkg::link_word_t act);
        if (exp !== act) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (exp !== act) begin
            $display("** Error: %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("** Error: %s expected %0d actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    // Expected SPI reply for a word forwarded in pipe mode
    function automatic link_pkg::link_word_t expected_reply(input logic [7:0] id,
                                                            input logic [7:0] code);
        link_pkg::link_word_t r;
        r.chan_id = id;
        r.code    = code ^ 8'h5A;
        if (id == 8'd3) begin
            r.chan_id = link_pkg::ERR_ID;
            r.code    = link_pkg::ERR_TIMEOUT;
        end else if (id == 8'd5) begin
            r.chan_id = link_pkg::ERR_ID;
            r.code    = link_pkg::ERR_PARITY;
        end
        return r;
    endfunction

    task automatic send_word(input logic [7:0] id, input logic [7:0] code, input logic pipe);
        send_q.push_back({id, code});
        if (id < 8'(NCH)) begin
            exp_ch.push_back(int'(id));
            exp_code.push_back(code);
            if (pipe) begin
                exp_reply.push_back(expected_reply(id, code));
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            fail_plain("Timeout: the run stalled before all words were served");
        end
        if (take) begin
            void'(send_q.pop_front());
        end
        // Queue head for the next chip select
        next_avail = (send_q.size() != 0);
        next_word  = next_avail ? send_q[0] : link_pkg::NOP_WORD;
        if (got_word && word != link_pkg::NOP_WORD) begin
            if (exp_reply.size() == 0) begin
                fail_plain("SPI reply word arrived with no reply pending");
            end
            check_word("pipe reply", exp_reply.pop_front(), word);
        end
        for (int k = 0; k < NCH; k++) begin
            if (byte_valid[k]) begin
                if (exp_ch.size() == 0 || exp_ch[0] != k) begin
                    fail_plain($sformatf("Unexpected byte on uart_tx[%0d]", k));
                end
                void'(exp_ch.pop_front());
                check_byte("module byte", exp_code.pop_front(), byte_data[k]);
            end
        end
    end

    // Shoot pulse width in clocks
    always @(negedge clk) begin
        if (shoot) begin
            shoot_len = shoot_len + 1;
        end else if (shoot_len != 0) begin
            check_count("shoot width", board_pkg::SHOOT_CYCLES, shoot_len);
            shoot_pulses = shoot_pulses + 1;
            shoot_len    = 0;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(negedge clk);
        check_level("reset cs_n", 1'b1, spi_cs_n);
        check_level("reset uart_tx", 1'b1, &uart_tx);
        check_level("reset shoot", 1'b0, shoot);
        check_level("reset led_pipe", 1'b0, led_pipe);
        check_level("reset led_normal", 1'b0, led_normal);
        rst = 1'b0;

        // Normal mode once the startup window runs out
        while (!led_normal) begin
            @(negedge clk);
            startup_wait = startup_wait + 1;
        end
        check_count("startup window", board_pkg::STARTUP_CYCLES, startup_wait);
        check_level("normal led_pipe", 1'b0, led_pipe);
        send_word(8'd0, 8'h11, 1'b0);
        send_word(8'd4, 8'h22, 1'b0);
        send_word(8'd12, 8'h33, 1'b0);
        send_word(link_pkg::SHOOT_ID, 8'h00, 1'b0);
        send_word(8'd8, 8'h44, 1'b0);
        while (send_q.size() != 0 || exp_ch.size() != 0) @(negedge clk);
        repeat (SETTLE / 2) @(negedge clk);
        check_count("shoot pulses", 1, shoot_pulses);

        // Pipe mode after a fresh reset
        apply_reset();
        send_q.push_back(link_pkg::PIPE_MODE_CMD);
        send_word(8'd0, 8'h10, 1'b1);
        send_word(8'd3, 8'h20, 1'b1);
        send_word(8'd5, 8'h30, 1'b1);
        send_word(8'd7, 8'h40, 1'b1);
        send_word(8'd12, 8'h01, 1'b1);
        send_word(link_pkg::SHOOT_ID, 8'h00, 1'b1);
        send_word(8'd2, 8'h55, 1'b1);
        send_word(8'd8, 8'h66, 1'b1);
        while (!led_pipe) @(negedge clk);
        while (exp_reply.size() != 0 || exp_ch.size() != 0) @(negedge clk);
        repeat (SETTLE / 3) @(negedge clk);
        check_level("pipe led_normal", 1'b0, led_normal);
        check_count("shoot pulses", 1, shoot_pulses);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== tb.f ====
hw/link_pkg.sv
hw/board_pkg.sv
hw/link_ifs.sv
hw/spi_master.sv
hw/uart_channel.sv
hw/link_controller.sv
hw/inverter_link_top.sv
test/tb_models.sv
test/tb_inverter_link.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run; success only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_inverter_link \
    -f tb.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
